// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_rv_soc
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
rv_pkg.sv
rv_alu.sv
rv_decode.sv
rv_reg_file.sv
rv_fetch.sv
rv_lsu.sv
rv_core.sv
wb_arbiter.sv
rv_soc_top.sv
tb_clock.sv
tb_rv_soc_props.sv
tb_rv_soc.sv

// File: rv_alu.sv
// integer alu
`timescale 1ns/1ps
module rv_alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   res,
    output logic            zero
);
    always_comb begin
        case (op)
            rv_pkg::alu_add:    res = a + b;
            rv_pkg::alu_sub:    res = a - b;
            rv_pkg::alu_and:    res = a & b;
            rv_pkg::alu_or:     res = a | b;
            rv_pkg::alu_xor:    res = a ^ b;
            rv_pkg::alu_slt: begin
                // signed compare
                res = {{(rv_pkg::xlen-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            rv_pkg::alu_pass_b: res = b;
            default:            res = a + b;
        endcase
    end

    assign zero = (res == '0);  // drives beq/bne

endmodule

// File: rv_core.sv
// multi-cycle rv32i core
`timescale 1ns/1ps
module rv_core (
    input  logic          clk,
    input  logic          reset,
    input  logic          ibus_ack,
    input  rv_pkg::word_t ibus_dat_r,
    output logic          ibus_cyc,
    output logic          ibus_stb,
    output rv_pkg::addr_t ibus_adr,
    input  logic          dbus_ack,
    input  rv_pkg::word_t dbus_dat_r,
    output logic          dbus_cyc,
    output logic          dbus_stb,
    output logic          dbus_we,
    output rv_pkg::addr_t dbus_adr,
    output rv_pkg::word_t dbus_dat_w,
    output logic          halted,
    output logic          illegal
);
    typedef enum logic [2:0] {st_fetch, st_exec, st_mem, st_wb, st_halt} state_t;

    state_t            state;
    logic              illegal_q;
    logic              fetch_start, fetch_done, mem_start, mem_done;
    rv_pkg::addr_t     pc, next_pc, pc_plus4;
    rv_pkg::word_t     instr, load_data, imm, rdata1, rdata2, alu_b, alu_res, wdata;
    rv_pkg::reg_addr_t rs1, rs2, rd;
    rv_pkg::alu_op_t   alu_op;
    logic              reg_wen, alu_use_imm, alu_zero, taken;
    logic              is_load, is_store, is_branch, branch_ne;
    logic              is_jal, is_jalr, is_ebreak, dec_illegal;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_fetch;
            illegal_q <= 1'b0;
        end else begin
            case (state)
                st_fetch: if (fetch_done) state <= st_exec;
                st_exec: begin
                    if (dec_illegal) begin
                        state     <= st_halt;
                        illegal_q <= 1'b1;
                    end else if (is_ebreak)
                        state <= st_halt;
                    else if (is_load || is_store)
                        state <= st_mem;
                    else
                        state <= st_wb;
                end
                st_mem:   if (mem_done) state <= st_wb;
                st_wb:    state <= st_fetch;
                default:  state <= st_halt;   // stuck until reset
            endcase
        end
    end

    // start pulses while the unit is idle
    assign fetch_start = (state == st_fetch) && !ibus_cyc;
    assign mem_start   = (state == st_mem) && !dbus_cyc;
    assign halted      = (state == st_halt);
    assign illegal     = illegal_q;

    assign alu_b    = alu_use_imm ? imm : rdata2;
    assign pc_plus4 = pc + 32'd4;
    assign taken    = is_branch && (alu_zero ^ branch_ne);
    assign wdata    = is_load ? load_data : (is_jal || is_jalr) ? pc_plus4 : alu_res;

    always_comb begin
        if (is_jalr)
            next_pc = {alu_res[rv_pkg::xlen-1:1], 1'b0};
        else if (is_jal || taken)
            next_pc = pc + imm;
        else
            next_pc = pc_plus4;
    end

    rv_fetch u_fetch (
        .clk(clk), .reset(reset),
        .fetch_start(fetch_start), .pc_load(state == st_wb), .next_pc(next_pc),
        .wb_ack(ibus_ack), .wb_dat_r(ibus_dat_r),
        .pc(pc), .instr(instr), .fetch_done(fetch_done),
        .wb_cyc(ibus_cyc), .wb_stb(ibus_stb), .wb_adr(ibus_adr)
    );

    rv_lsu u_lsu (
        .clk(clk), .reset(reset),
        .mem_start(mem_start), .mem_write(is_store), .mem_addr(alu_res),
        .store_data(rdata2), .wb_ack(dbus_ack), .wb_dat_r(dbus_dat_r),
        .load_data(load_data), .mem_done(mem_done),
        .wb_cyc(dbus_cyc), .wb_stb(dbus_stb), .wb_we(dbus_we),
        .wb_adr(dbus_adr), .wb_dat_w(dbus_dat_w)
    );

    rv_decode u_decode (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .reg_wen(reg_wen),
        .alu_op(alu_op), .alu_use_imm(alu_use_imm), .imm(imm),
        .is_load(is_load), .is_store(is_store), .is_branch(is_branch),
        .branch_ne(branch_ne), .is_jal(is_jal), .is_jalr(is_jalr),
        .is_ebreak(is_ebreak), .illegal(dec_illegal)
    );

    rv_reg_file u_regs (
        .clk(clk), .reset(reset),
        .wen(reg_wen && state == st_wb), .waddr(rd), .wdata(wdata),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rdata1), .rdata2(rdata2)
    );

    rv_alu u_alu (
        .op(alu_op), .a(rdata1), .b(alu_b), .res(alu_res), .zero(alu_zero)
    );

endmodule

// File: rv_decode.sv
// instruction decoder
`timescale 1ns/1ps
module rv_decode (
    input  rv_pkg::word_t     instr,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output logic              reg_wen,
    output rv_pkg::alu_op_t   alu_op,
    output logic              alu_use_imm,
    output rv_pkg::word_t     imm,
    output logic              is_load,
    output logic              is_store,
    output logic              is_branch,
    output logic              branch_ne,
    output logic              is_jal,
    output logic              is_jalr,
    output logic              is_ebreak,
    output logic              illegal
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv_pkg::imm_kind_t imm_kind;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        reg_wen     = 1'b0;
        alu_op      = rv_pkg::alu_add;
        alu_use_imm = 1'b0;
        imm_kind    = rv_pkg::imm_i;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_branch   = 1'b0;
        branch_ne   = funct3[0];   // only 000 and 001 survive below
        is_jal      = 1'b0;
        is_jalr     = 1'b0;
        is_ebreak   = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            rv_pkg::op_reg: begin
                reg_wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = rv_pkg::alu_add;
                    {7'b0100000, 3'b000}: alu_op = rv_pkg::alu_sub;
                    {7'b0000000, 3'b111}: alu_op = rv_pkg::alu_and;
                    {7'b0000000, 3'b110}: alu_op = rv_pkg::alu_or;
                    {7'b0000000, 3'b100}: alu_op = rv_pkg::alu_xor;
                    {7'b0000000, 3'b010}: alu_op = rv_pkg::alu_slt;
                    default:              illegal = 1'b1;
                endcase
            end
            rv_pkg::op_imm: begin  // addi only
                reg_wen     = 1'b1;
                alu_use_imm = 1'b1;
                illegal     = (funct3 != 3'b000);
            end
            rv_pkg::op_lui: begin
                reg_wen     = 1'b1;
                alu_op      = rv_pkg::alu_pass_b;
                alu_use_imm = 1'b1;
                imm_kind    = rv_pkg::imm_u;
            end
            rv_pkg::op_load: begin
                reg_wen     = 1'b1;
                alu_use_imm = 1'b1;
                is_load     = 1'b1;
                illegal     = (funct3 != 3'b010);   // lw only
            end
            rv_pkg::op_store: begin
                alu_use_imm = 1'b1;
                imm_kind    = rv_pkg::imm_s;
                is_store    = 1'b1;
                illegal     = (funct3 != 3'b010);
            end
            rv_pkg::op_branch: begin
                alu_op    = rv_pkg::alu_sub;    // compare via zero flag
                imm_kind  = rv_pkg::imm_b;
                is_branch = 1'b1;
                illegal   = (funct3[2:1] != 2'b00);
            end
            rv_pkg::op_jal: begin
                reg_wen  = 1'b1;
                imm_kind = rv_pkg::imm_j;
                is_jal   = 1'b1;
            end
            rv_pkg::op_jalr: begin
                reg_wen     = 1'b1;
                alu_use_imm = 1'b1;   // target is rs1 + imm
                is_jalr     = 1'b1;
                illegal     = (funct3 != 3'b000);
            end
            rv_pkg::op_system: begin
                is_ebreak = (instr == rv_pkg::ebreak_word);
                illegal   = (instr != rv_pkg::ebreak_word);
            end
            default: illegal = 1'b1;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        case (imm_kind)
            rv_pkg::imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::imm_b: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
            rv_pkg::imm_u: imm = {instr[31:12], 12'b0};
            rv_pkg::imm_j: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
            default:       imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// File: rv_fetch.sv
// instruction fetch master
`timescale 1ns/1ps
module rv_fetch (
    input  logic          clk,
    input  logic          reset,
    input  logic          fetch_start,
    input  logic          pc_load,
    input  rv_pkg::addr_t next_pc,
    input  logic          wb_ack,
    input  rv_pkg::word_t wb_dat_r,
    output rv_pkg::addr_t pc,
    output rv_pkg::word_t instr,
    output logic          fetch_done,
    output logic          wb_cyc,
    output logic          wb_stb,
    output rv_pkg::addr_t wb_adr
);
    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= rv_pkg::reset_pc;
            wb_cyc <= 1'b0;
        end else begin
            if (pc_load)
                pc <= next_pc;
            if (fetch_start)
                wb_cyc <= 1'b1;
            else if (fetch_done)
                wb_cyc <= 1'b0;     // drop in the ack cycle
        end
    end

    // instruction word held until the next fetch
    always_ff @(posedge clk) begin
        if (fetch_done)
            instr <= wb_dat_r;
    end

    assign fetch_done = wb_cyc & wb_ack;
    assign wb_stb     = wb_cyc;
    assign wb_adr     = pc;     // pc is steady for the whole cycle

endmodule

// File: rv_lsu.sv
// load/store data master
`timescale 1ns/1ps
module rv_lsu (
    input  logic          clk,
    input  logic          reset,
    input  logic          mem_start,
    input  logic          mem_write,
    input  rv_pkg::addr_t mem_addr,
    input  rv_pkg::word_t store_data,
    input  logic          wb_ack,
    input  rv_pkg::word_t wb_dat_r,
    output rv_pkg::word_t load_data,
    output logic          mem_done,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output rv_pkg::addr_t wb_adr,
    output rv_pkg::word_t wb_dat_w
);
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_cyc <= 1'b0;
            wb_we  <= 1'b0;
        end else if (mem_start) begin
            wb_cyc <= 1'b1;
            wb_we  <= mem_write;
        end else if (mem_done) begin
            wb_cyc <= 1'b0;
            wb_we  <= 1'b0;
        end
    end

    // address and store data frozen at start
    always_ff @(posedge clk) begin
        if (mem_start) begin
            wb_adr   <= mem_addr;
            wb_dat_w <= store_data;
        end
        if (mem_done && !wb_we)
            load_data <= wb_dat_r;
    end

    assign mem_done = wb_cyc & wb_ack;
    assign wb_stb   = wb_cyc;

endmodule

// File: rv_pkg.sv
// rv32i core shared definitions
package rv_pkg;

    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    typedef logic [xlen-1:0]           word_t;
    typedef logic [xlen-1:0]           addr_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    localparam addr_t reset_pc = 32'h0000_0000;

    // alu operations
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    // immediate formats
    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_kind_t;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam word_t ebreak_word = 32'h0010_0073;

endpackage

// File: rv_reg_file.sv
// register file
`timescale 1ns/1ps
module rv_reg_file (
    input  logic              clk,
    input  logic              reset,
    input  logic              wen,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);
    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 always reads zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rv_soc_top.sv
// rv32i soc top level
`timescale 1ns/1ps
module rv_soc_top (
    input  logic          clk,
    input  logic          reset,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output rv_pkg::addr_t wb_adr,
    output rv_pkg::word_t wb_dat_w,
    input  logic          wb_ack,
    input  rv_pkg::word_t wb_dat_r,
    output logic          halted,
    output logic          illegal
);
    logic          i_cyc, i_stb, i_ack;
    rv_pkg::addr_t i_adr;
    rv_pkg::word_t i_dat_r;
    logic          d_cyc, d_stb, d_we, d_ack;
    rv_pkg::addr_t d_adr;
    rv_pkg::word_t d_dat_w, d_dat_r;

    rv_core u_core (
        .clk(clk), .reset(reset),
        .ibus_ack(i_ack), .ibus_dat_r(i_dat_r),
        .ibus_cyc(i_cyc), .ibus_stb(i_stb), .ibus_adr(i_adr),
        .dbus_ack(d_ack), .dbus_dat_r(d_dat_r),
        .dbus_cyc(d_cyc), .dbus_stb(d_stb), .dbus_we(d_we),
        .dbus_adr(d_adr), .dbus_dat_w(d_dat_w),
        .halted(halted), .illegal(illegal)
    );

    // lsu on m0 for priority, fetch is read-only
    wb_arbiter u_arb (
        .clk(clk), .reset(reset),
        .m0_cyc(d_cyc), .m0_stb(d_stb), .m0_we(d_we), .m0_adr(d_adr),
        .m0_dat_w(d_dat_w), .m0_ack(d_ack), .m0_dat_r(d_dat_r),
        .m1_cyc(i_cyc), .m1_stb(i_stb), .m1_we(1'b0), .m1_adr(i_adr),
        .m1_dat_w('0), .m1_ack(i_ack), .m1_dat_r(i_dat_r),
        .s_cyc(wb_cyc), .s_stb(wb_stb), .s_we(wb_we), .s_adr(wb_adr),
        .s_dat_w(wb_dat_w), .s_ack(wb_ack), .s_dat_r(wb_dat_r)
    );

endmodule

// File: tb_clock.sv
// testbench clock source
`timescale 1ns/1ps
module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;  // 20 ns period

endmodule

// File: tb_rv_soc.sv
// rv32i soc testbench
`timescale 1ns/1ps
module tb_rv_soc;
    localparam int n_rand   = 40;           // random instruction slots
    localparam int prog_len = n_rand + 33;  // base setup, stores of x1..x31, final word

    logic          clk, reset, wb_cyc, wb_stb, wb_we, wb_ack, halted, illegal;
    rv_pkg::addr_t wb_adr;
    rv_pkg::word_t wb_dat_w, wb_dat_r;

    rv_pkg::word_t mem [256];
    rv_pkg::word_t model_mem [256];
    rv_pkg::addr_t exp_reads [$];   // fetch and load addresses in order
    rv_pkg::addr_t exp_st_adr [$];
    rv_pkg::word_t exp_st_dat [$];
    logic          pending;
    int            waits;

    tb_clock u_clock (.clk(clk));

    rv_soc_top u_dut (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
        .halted(halted), .illegal(illegal)
    );

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(input string name, input rv_pkg::addr_t exp,
                              input rv_pkg::addr_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t exp,
                              input rv_pkg::word_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input bit act);
        if (exp !== act) begin
            $display("ERR %s expected %0b actual %0b", name, exp, act);
            abort_run();
        end
    endtask

    function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
    endfunction

    function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
    endfunction

    // random program with forward-only control flow
    task automatic gen_program(input bit with_illegal);
        int i, kind, t;
        logic [4:0] rd, ra, rb;
        logic [11:0] imm;
        for (int a = 0; a < 256; a++) begin
            mem[a] = (rv_pkg::word_t'(a) * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
        end
        mem[0] = enc_i(12'd512, 5'd0, 3'b000, 5'd1, rv_pkg::op_imm);   // x1 = data base
        i = 1;
        while (i <= n_rand) begin
            kind = int'($urandom_range(9, 0));
            rd   = 5'($urandom_range(31, 2));
            ra   = 5'($urandom_range(31, 0));
            rb   = 5'($urandom_range(31, 0));
            imm  = 12'($urandom);
            t    = i + int'($urandom_range(4, 1));
            if (t > n_rand + 1)
                t = n_rand + 1;
            case (kind)
                0: begin
                    case ($urandom_range(5, 0))
                        0: mem[i] = {7'h00, rb, ra, 3'b000, rd, rv_pkg::op_reg};
                        1: mem[i] = {7'h20, rb, ra, 3'b000, rd, rv_pkg::op_reg};
                        2: mem[i] = {7'h00, rb, ra, 3'b111, rd, rv_pkg::op_reg};
                        3: mem[i] = {7'h00, rb, ra, 3'b110, rd, rv_pkg::op_reg};
                        4: mem[i] = {7'h00, rb, ra, 3'b100, rd, rv_pkg::op_reg};
                        default: mem[i] = {7'h00, rb, ra, 3'b010, rd, rv_pkg::op_reg};
                    endcase
                end
                1: mem[i] = enc_i(imm, ra, 3'b000, rd, rv_pkg::op_imm);
                2: mem[i] = {20'($urandom), rd, rv_pkg::op_lui};
                3: mem[i] = enc_i(12'(4 * $urandom_range(15, 0)), 5'd1, 3'b010, rd,
                                  rv_pkg::op_load);
                4: mem[i] = enc_s(12'(4 * $urandom_range(15, 0)), rb, 5'd1);
                5: mem[i] = enc_b(13'(4 * (t - i)), rb, ra, 3'b000);
                6: mem[i] = enc_b(13'(4 * (t - i)), rb, ra, 3'b001);
                7: mem[i] = enc_b(13'(4 * (t - i)), ra, ra, 3'b000);   // always taken
                8: mem[i] = enc_j(21'(4 * (t - i)), rd);
                default: begin
                    // jalr off the data base held in x1
                    mem[i] = enc_i(12'(4 * t - 512), 5'd1, 3'b000, rd, rv_pkg::op_jalr);
                end
            endcase
            i++;
        end
        for (int r = 1; r < 32; r++) begin
            mem[n_rand + r] = enc_s(12'(128 + 4 * r), 5'(r), 5'd1);
        end
        mem[n_rand + 32] = with_illegal ? 32'hFFFF_FFFF : rv_pkg::ebreak_word;
    endtask

    // instruction-set model on its own memory copy
    task automatic run_model();
        rv_pkg::addr_t pc, next, addr;
        rv_pkg::word_t regs [32];
        rv_pkg::word_t w, a, b, wval, imm_i, imm_s, imm_b, imm_j;
        bit done, wen;
        model_mem = mem;
        foreach (regs[r]) regs[r] = '0;
        exp_reads.delete();
        exp_st_adr.delete();
        exp_st_dat.delete();
        pc   = rv_pkg::reset_pc;
        done = 1'b0;
        while (!done) begin
            exp_reads.push_back(pc);
            w     = model_mem[pc[9:2]];
            a     = regs[w[19:15]];
            b     = regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            next  = pc + 32'd4;
            wen   = 1'b1;
            wval  = '0;
            case (w[6:0])
                rv_pkg::op_reg: begin
                    case ({w[30], w[14:12]})
                        4'b0000: wval = a + b;
                        4'b1000: wval = a - b;
                        4'b0111: wval = a & b;
                        4'b0110: wval = a | b;
                        4'b0100: wval = a ^ b;
                        default: wval = {31'b0, $signed(a) < $signed(b)};
                    endcase
                end
                rv_pkg::op_imm: wval = a + imm_i;
                rv_pkg::op_lui: wval = {w[31:12], 12'b0};
                rv_pkg::op_load: begin
                    addr = a + imm_i;
                    exp_reads.push_back(addr);
                    wval = model_mem[addr[9:2]];
                end
                rv_pkg::op_store: begin
                    wen  = 1'b0;
                    addr = a + imm_s;
                    exp_st_adr.push_back(addr);
                    exp_st_dat.push_back(b);
                    model_mem[addr[9:2]] = b;
                end
                rv_pkg::op_branch: begin
                    wen = 1'b0;
                    if ((a == b) != w[12])
                        next = pc + imm_b;
                end
                rv_pkg::op_jal: begin
                    wval = pc + 32'd4;
                    next = pc + imm_j;
                end
                rv_pkg::op_jalr: begin
                    wval = pc + 32'd4;
                    next = (a + imm_i) & ~32'd1;
                end
                default: begin
                    wen  = 1'b0;
                    done = 1'b1;    // ebreak or illegal word
                end
            endcase
            if (wen && w[11:7] != 5'd0)
                regs[w[11:7]] = wval;
            pc = next;
        end
    endtask

    task automatic serve_transfer();
        if (wb_adr >= 32'd1024) begin
            $display("bus address %h is outside memory", wb_adr);
            abort_run();
        end
        if (wb_we) begin
            check_flag("store expected", 1'b1, exp_st_adr.size() > 0);
            check_addr("store address", exp_st_adr.pop_front(), wb_adr);
            check_word("store data", exp_st_dat.pop_front(), wb_dat_w);
            mem[wb_adr[9:2]] = wb_dat_w;
        end else begin
            check_flag("read expected", 1'b1, exp_reads.size() > 0);
            check_addr("read address", exp_reads.pop_front(), wb_adr);
            wb_dat_r = mem[wb_adr[9:2]];
        end
    endtask

    // memory slave with 0 to 3 wait states
    always @(negedge clk) begin
        if (reset) begin
            wb_ack  = 1'b0;
            pending = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!pending) begin
                if (halted) begin
                    $display("a bus cycle started after the core halted");
                    abort_run();
                end
                pending = 1'b1;
                waits   = int'($urandom_range(3, 0));
            end
            if (waits == 0) begin
                serve_transfer();
                wb_ack  = 1'b1;
                pending = 1'b0;
            end else begin
                waits--;
            end
        end
    end

    task automatic run_program(input string name, input bit with_illegal);
        int cycles, limit;
        bit seen_first;
        limit = prog_len * 6 * 2 + 100;
        reset = 1'b1;
        gen_program(with_illegal);
        run_model();
        repeat (8) @(negedge clk);
        check_flag({name, " cyc after reset"}, 1'b0, wb_cyc);
        check_flag({name, " stb after reset"}, 1'b0, wb_stb);
        check_flag({name, " we after reset"}, 1'b0, wb_we);
        check_flag({name, " halted after reset"}, 1'b0, halted);
        check_flag({name, " illegal after reset"}, 1'b0, illegal);
        reset      = 1'b0;
        cycles     = 0;
        seen_first = 1'b0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            if (wb_cyc && !seen_first) begin
                check_addr({name, " first fetch"}, rv_pkg::reset_pc, wb_adr);
                check_flag({name, " first fetch is a read"}, 1'b0, wb_we);
                seen_first = 1'b1;
            end
            if (cycles > limit) begin
                $display("%s timed out after %0d cycles without halting", name, cycles);
                abort_run();
            end
        end
        repeat (10) @(negedge clk);   // bus must stay quiet
        check_flag({name, " halted"}, 1'b1, halted);
        check_flag({name, " illegal"}, with_illegal, illegal);
        check_flag({name, " all reads seen"}, 1'b1, exp_reads.size() == 0);
        check_flag({name, " all stores seen"}, 1'b1, exp_st_adr.size() == 0);
    endtask

    initial begin
        reset    = 1'b1;
        wb_ack   = 1'b0;
        wb_dat_r = '0;
        pending  = 1'b0;
        waits    = 0;
        void'($urandom(39));
        run_program("ebreak_run", 1'b0);
        run_program("illegal_run", 1'b1);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: tb_rv_soc_props.sv
// wishbone protocol assertions
`timescale 1ns/1ps
module tb_rv_soc_props (
    input logic          clk,
    input logic          reset,
    input logic          m0_cyc,
    input logic          m0_stb,
    input logic          m0_ack,
    input logic          m1_cyc,
    input logic          m1_stb,
    input logic          m1_ack,
    input logic          s_cyc,
    input logic          s_stb,
    input logic          s_we,
    input logic          s_ack,
    input rv_pkg::addr_t s_adr,
    input rv_pkg::word_t s_dat_w
);
    stb_with_cyc: assert property (@(posedge clk) disable iff (reset)
        (!s_stb || s_cyc) && (!m0_stb || m0_cyc) && (!m1_stb || m1_cyc))
        else $error("stb high without cyc");

    // request held until the slave answers
    hold_until_ack: assert property (@(posedge clk) disable iff (reset)
        (s_cyc && s_stb && !s_ack) |=> ($stable(s_adr) && $stable(s_we) && $stable(s_dat_w)))
        else $error("request changed before ack");

    single_ack: assert property (@(posedge clk) disable iff (reset) !(m0_ack && m1_ack))
        else $error("both masters acked");

    ack_with_stb: assert property (@(posedge clk) disable iff (reset)
        (!s_ack || s_stb) && (!m0_ack || m0_stb) && (!m1_ack || m1_stb))
        else $error("ack without stb");

endmodule

bind wb_arbiter tb_rv_soc_props u_props (
    .clk(clk), .reset(reset),
    .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_ack(m0_ack),
    .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_ack(m1_ack),
    .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_ack(s_ack),
    .s_adr(s_adr), .s_dat_w(s_dat_w)
);

// File: wb_arbiter.sv
// two-master wishbone arbiter
`timescale 1ns/1ps
module wb_arbiter (
    input  logic          clk,
    input  logic          reset,
    input  logic          m0_cyc,
    input  logic          m0_stb,
    input  logic          m0_we,
    input  rv_pkg::addr_t m0_adr,
    input  rv_pkg::word_t m0_dat_w,
    output logic          m0_ack,
    output rv_pkg::word_t m0_dat_r,
    input  logic          m1_cyc,
    input  logic          m1_stb,
    input  logic          m1_we,
    input  rv_pkg::addr_t m1_adr,
    input  rv_pkg::word_t m1_dat_w,
    output logic          m1_ack,
    output rv_pkg::word_t m1_dat_r,
    output logic          s_cyc,
    output logic          s_stb,
    output logic          s_we,
    output rv_pkg::addr_t s_adr,
    output rv_pkg::word_t s_dat_w,
    input  logic          s_ack,
    input  rv_pkg::word_t s_dat_r
);
    logic busy;
    logic grant;    // 0 = m0, 1 = m1
    logic sel;

    // fixed priority when idle, m0 first
    assign sel = busy ? grant : !m0_cyc;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            grant <= 1'b0;
        end else if (!busy) begin
            if (s_cyc && !s_ack) begin  // zero-wait cycles never lock
                busy  <= 1'b1;
                grant <= sel;
            end
        end else if (!s_cyc || s_ack) begin
            busy <= 1'b0;
        end
    end

    assign s_cyc   = sel ? m1_cyc : m0_cyc;
    assign s_stb   = sel ? m1_stb : m0_stb;
    assign s_we    = sel ? m1_we : m0_we;
    assign s_adr   = sel ? m1_adr : m0_adr;
    assign s_dat_w = sel ? m1_dat_w : m0_dat_w;

    assign m0_ack   = s_ack && !sel;
    assign m1_ack   = s_ack && sel;
    assign m0_dat_r = s_dat_r;
    assign m1_dat_r = s_dat_r;

endmodule
